/* sources.f */
rtl/rob_pkg.sv
rtl/rob_commit_if.sv
rtl/rob_thread_queue.sv
rtl/rob_commit_arbiter.sv
rtl/smt_rob.sv
dv/smt_rob_chk.sv
dv/smt_rob_tb.sv

/* dv/smt_rob_tests.txt */
# test <name> | disp <thread> <count> <pc1> <branch1> <pc2> <branch2> | wait <cycles> | end
# cpl <dispatch index> <mispredict> <target> | exp <thread> <pc> <target> | flush <pc never committed>
test order
disp 0 2 100 0 104 0
disp 0 2 108 1 10c 0
cpl 3 0 0
cpl 2 0 500
cpl 0 0 0
cpl 1 0 0
wait 4
exp 0 100 0
exp 0 104 0
exp 0 108 500
exp 0 10c 0
end
test dual
disp 0 2 200 0 204 0
disp 1 2 300 0 304 0
disp 0 1 208 0 0 0
disp 1 1 308 0 0 0
cpl 0 0 0
cpl 1 0 0
cpl 2 0 0
cpl 3 0 0
cpl 4 0 0
cpl 5 0 0
wait 4
exp 0 200 0
exp 0 204 0
exp 0 208 0
exp 1 300 0
exp 1 304 0
exp 1 308 0
end
test flush
disp 0 2 400 0 404 1
disp 1 2 600 0 604 0
disp 0 2 408 0 40c 0
cpl 0 0 0
cpl 1 1 800
cpl 2 0 0
cpl 3 0 0
cpl 4 0 0
cpl 5 0 0
wait 6
exp 0 400 0
exp 0 404 800
exp 1 600 0
exp 1 604 0
flush 408
flush 40c
end
test refill
disp 1 2 700 0 704 0
disp 1 2 708 0 70c 0
disp 1 2 710 1 714 0
disp 1 2 718 0 71c 0
cpl 0 0 0
cpl 1 0 0
cpl 2 0 0
cpl 3 0 0
cpl 4 0 a00
cpl 5 0 0
cpl 6 0 0
cpl 7 0 0
wait 4
exp 1 700 0
exp 1 704 0
exp 1 708 0
exp 1 70c 0
exp 1 710 a00
exp 1 714 0
exp 1 718 0
exp 1 71c 0
end

/* dv/smt_rob_tb.sv */
/*
	Testbench for smt_rob at DEPTH 8, driven from dv/smt_rob_tests.txt.
	Each test must fit the credits of an empty buffer and drains before the next.
*/
`timescale 1ns/1ps
`default_nettype none

module smt_rob_tb;

	localparam int DEPTH = 8;

	logic clock;
	logic reset;
	logic dispatch_thread;
	logic [1:0] dispatch_count;
	logic [63:0] dispatch1_pc, dispatch2_pc;
	logic [4:0] dispatch1_arn, dispatch2_arn;
	logic [5:0] dispatch1_prn, dispatch2_prn;
	logic dispatch1_is_branch, dispatch2_is_branch;
	logic complete1_valid, complete2_valid;
	logic [3:0] complete1_tag, complete2_tag;
	logic complete1_mispredict, complete2_mispredict;
	logic [63:0] complete1_target_pc, complete2_target_pc;
	logic commit0_valid, commit0_thread, commit0_is_branch, commit0_mispredict;
	logic commit1_valid, commit1_thread, commit1_is_branch, commit1_mispredict;
	logic [63:0] commit0_pc, commit0_target_pc, commit1_pc, commit1_target_pc;
	logic [4:0] commit0_arn, commit1_arn;
	logic [5:0] commit0_prn, commit1_prn;
	logic [3:0] dispatch_tag1, dispatch_tag2;
	logic [3:0] credit_t0, credit_t1;

	int errors = 0;
	int limit_cycles = 0;
	integer seed = 32'hce5d_1b41;
	logic monitoring = 1'b0;
	logic prev_mixed = 1'b0;
	logic prev_s0 = 1'b0;
	logic mixed;
	string test_name;
	int wait_n;
	int credit_sum [2];
	int disp_n [2];
	logic [2:0] base_slot [2];	// tail slot per thread when a test starts
	// one entry per disp line
	int g_thr[$], g_cnt[$], g_br1[$], g_br2[$];
	logic [63:0] g_pc1[$], g_pc2[$];
	logic [3:0] d_tag[$];		// tag per dispatch index
	logic [63:0] d_pc[$];		// pc per dispatch index
	logic br_of_pc [logic [63:0]];
	logic misp_of_pc [logic [63:0]];
	int c_idx[$], c_misp[$];
	logic [63:0] c_tgt[$];
	int exp_thr[$], got_thr[$];
	logic [63:0] exp_pc[$], exp_tgt[$], got_pc[$], got_tgt[$], fl_pc[$];

	smt_rob #(.DEPTH(DEPTH)) dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [4:0] arn_of(logic [63:0] pc);
		return pc[6:2];
	endfunction

	function automatic logic [5:0] prn_of(logic [63:0] pc);
		return pc[7:2];
	endfunction

	task automatic record_commit(logic thr, logic [63:0] pc, logic [63:0] tgt,
		logic [4:0] arn, logic [5:0] prn, logic br, logic mp);
		if (arn != arn_of(pc) || prn != prn_of(pc))
		begin
			$display("** Error %s: pc %h expected arn/prn %h/%h, actual %h/%h",
				test_name, pc, arn_of(pc), prn_of(pc), arn, prn);
			errors++;
		end
		if (!br_of_pc.exists(pc))
		begin
			$display("pc %h committed in test %s was never dispatched", pc, test_name);
			errors++;
		end
		else if (br != br_of_pc[pc] || mp != misp_of_pc[pc])
		begin
			$display("** Error %s: pc %h expected branch/mispredict %0d/%0d, actual %0d/%0d",
				test_name, pc, br_of_pc[pc], misp_of_pc[pc], br, mp);
			errors++;
		end
		got_thr.push_back(thr);
		got_pc.push_back(pc);
		got_tgt.push_back(tgt);
	endtask

	// commit stream and credit monitor sampled mid-cycle
	always @(negedge clock)
	begin
		if (monitoring)
		begin
			if (commit0_valid)
				record_commit(commit0_thread, commit0_pc, commit0_target_pc, commit0_arn,
					commit0_prn, commit0_is_branch, commit0_mispredict);
			if (commit1_valid)
				record_commit(commit1_thread, commit1_pc, commit1_target_pc, commit1_arn,
					commit1_prn, commit1_is_branch, commit1_mispredict);
			credit_sum[0] += credit_t0;
			credit_sum[1] += credit_t1;
			mixed = commit0_valid && commit1_valid && (commit0_thread != commit1_thread);
			// slot 0 must swap threads when both heads are ready twice in a row
			if (mixed && prev_mixed && commit0_thread == prev_s0)
			begin
				$display("** Error %s: slot 0 thread expected %0d, actual %0d",
					test_name, !prev_s0, commit0_thread);
				errors++;
			end
			prev_mixed = mixed;
			prev_s0 = commit0_thread;
		end
	end

	task automatic clear_test();
		g_thr.delete();
		g_cnt.delete();
		g_br1.delete();
		g_br2.delete();
		g_pc1.delete();
		g_pc2.delete();
		d_tag.delete();
		d_pc.delete();
		br_of_pc.delete();
		misp_of_pc.delete();
		c_idx.delete();
		c_misp.delete();
		c_tgt.delete();
		exp_thr.delete();
		exp_pc.delete();
		exp_tgt.delete();
		fl_pc.delete();
		wait_n = 0;
	endtask

	task automatic drive_dispatches();
		logic [2:0] slot [2];
		logic [3:0] exp_tag;
		slot[0] = base_slot[0];
		slot[1] = base_slot[1];
		for (int i = 0; i < g_thr.size(); i++)
		begin
			@(posedge clock);
			dispatch_thread <= g_thr[i];
			dispatch_count <= g_cnt[i];
			dispatch1_pc <= g_pc1[i];
			dispatch1_arn <= arn_of(g_pc1[i]);
			dispatch1_prn <= prn_of(g_pc1[i]);
			dispatch1_is_branch <= g_br1[i];
			dispatch2_pc <= g_pc2[i];
			dispatch2_arn <= arn_of(g_pc2[i]);
			dispatch2_prn <= prn_of(g_pc2[i]);
			dispatch2_is_branch <= g_br2[i];
			disp_n[g_thr[i]] += g_cnt[i];
			br_of_pc[g_pc1[i]] = g_br1[i];
			misp_of_pc[g_pc1[i]] = 1'b0;
			d_pc.push_back(g_pc1[i]);
			if (g_cnt[i] == 2)
			begin
				br_of_pc[g_pc2[i]] = g_br2[i];
				misp_of_pc[g_pc2[i]] = 1'b0;
				d_pc.push_back(g_pc2[i]);
			end
			@(negedge clock);
			exp_tag = {g_thr[i][0], slot[g_thr[i]]};
			if (dispatch_tag1 != exp_tag)
			begin
				$display("** Error %s: first tag expected %h, actual %h",
					test_name, exp_tag, dispatch_tag1);
				errors++;
			end
			d_tag.push_back(dispatch_tag1);
			slot[g_thr[i]]++;
			if (g_cnt[i] == 2)
			begin
				exp_tag = {g_thr[i][0], slot[g_thr[i]]};
				if (dispatch_tag2 != exp_tag)
				begin
					$display("** Error %s: second tag expected %h, actual %h",
						test_name, exp_tag, dispatch_tag2);
					errors++;
				end
				d_tag.push_back(dispatch_tag2);
				slot[g_thr[i]]++;
			end
		end
		@(posedge clock);
		dispatch_count <= 2'd0;
	endtask

	task automatic drive_completions();
		int j;
		int tmp;
		logic [63:0] tt;
		foreach (c_idx[i])
			misp_of_pc[d_pc[c_idx[i]]] = c_misp[i];
		// shuffle the completion order
		for (int i = c_idx.size() - 1; i > 0; i--)
		begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = c_idx[i];
			c_idx[i] = c_idx[j];
			c_idx[j] = tmp;
			tmp = c_misp[i];
			c_misp[i] = c_misp[j];
			c_misp[j] = tmp;
			tt = c_tgt[i];
			c_tgt[i] = c_tgt[j];
			c_tgt[j] = tt;
		end
		for (int k = 0; k < c_idx.size(); k += 2)
		begin
			@(posedge clock);
			complete1_valid <= 1'b1;
			complete1_tag <= d_tag[c_idx[k]];
			complete1_mispredict <= c_misp[k];
			complete1_target_pc <= c_tgt[k];
			complete2_valid <= (k + 1 < c_idx.size());
			if (k + 1 < c_idx.size())
			begin
				complete2_tag <= d_tag[c_idx[k+1]];
				complete2_mispredict <= c_misp[k+1];
				complete2_target_pc <= c_tgt[k+1];
			end
		end
		@(posedge clock);
		complete1_valid <= 1'b0;
		complete2_valid <= 1'b0;
	endtask

	task automatic compare_commits();
		logic [63:0] ep[$], et[$], gp[$], gt[$];
		for (int thr = 0; thr < 2; thr++)
		begin
			ep.delete();
			et.delete();
			gp.delete();
			gt.delete();
			foreach (exp_pc[i])
				if (exp_thr[i] == thr)
				begin
					ep.push_back(exp_pc[i]);
					et.push_back(exp_tgt[i]);
				end
			foreach (got_pc[i])
				if (got_thr[i] == thr)
				begin
					gp.push_back(got_pc[i]);
					gt.push_back(got_tgt[i]);
				end
			if (ep.size() != gp.size())
			begin
				$display("** Error %s: thread %0d commits expected %0d, actual %0d",
					test_name, thr, ep.size(), gp.size());
				errors++;
			end
			for (int i = 0; i < ep.size() && i < gp.size(); i++)
				if (ep[i] != gp[i] || et[i] != gt[i])
				begin
					$display("** Error %s: commit %0d of thread %0d expected %h/%h, actual %h/%h",
						test_name, i, thr, ep[i], et[i], gp[i], gt[i]);
					errors++;
				end
			if (credit_sum[thr] != disp_n[thr])
			begin
				$display("** Error %s: thread %0d credits expected %0d, actual %0d",
					test_name, thr, disp_n[thr], credit_sum[thr]);
				errors++;
			end
		end
		foreach (fl_pc[i])
			foreach (got_pc[k])
				if (got_pc[k] == fl_pc[i])
				begin
					$display("flushed pc %h committed in test %s", fl_pc[i], test_name);
					errors++;
				end
	endtask

	task automatic run_test();
		got_thr.delete();
		got_pc.delete();
		got_tgt.delete();
		credit_sum[0] = 0;
		credit_sum[1] = 0;
		disp_n[0] = 0;
		disp_n[1] = 0;
		drive_dispatches();
		drive_completions();
		while (credit_sum[0] != disp_n[0] || credit_sum[1] != disp_n[1])
			@(posedge clock);
		repeat (wait_n) @(posedge clock);
		compare_commits();
		// a drained queue restarts right behind its last commit
		foreach (exp_thr[i])
			base_slot[exp_thr[i]]++;
	endtask

	// watchdog sized from the test file
	initial
	begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout, the buffer did not drain in time");
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		int fd;
		reg [8*160-1:0] line_buf;
		string lines[$];
		string kw;
		int t, c, b1, b2;
		logic [63:0] p1, p2, tg;
		reset = 1'b1;
		dispatch_thread = 1'b0;
		dispatch_count = 2'd0;
		{dispatch1_pc, dispatch1_arn, dispatch1_prn, dispatch1_is_branch} = '0;
		{dispatch2_pc, dispatch2_arn, dispatch2_prn, dispatch2_is_branch} = '0;
		{complete1_valid, complete1_tag, complete1_mispredict, complete1_target_pc} = '0;
		{complete2_valid, complete2_tag, complete2_mispredict, complete2_target_pc} = '0;
		base_slot[0] = '0;
		base_slot[1] = '0;
		test_name = "none";
		clear_test();
		fd = $fopen("dv/smt_rob_tests.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the test file dv/smt_rob_tests.txt");
			$display(">>> FAIL");
			$finish;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line_buf = '0;
				if ($fgets(line_buf, fd))
					lines.push_back(string'(line_buf));
			end
			$fclose(fd);
			limit_cycles = 200 * lines.size() + 20;
			repeat (8) @(posedge clock);
			reset <= 1'b0;
			@(posedge clock);
			monitoring = 1'b1;
			foreach (lines[n])
			begin
				kw = "";
				void'($sscanf(lines[n], "%s", kw));
				case (kw)
					"test": void'($sscanf(lines[n], "%s %s", kw, test_name));
					"disp":
					begin
						void'($sscanf(lines[n], "%s %d %d %h %d %h %d",
							kw, t, c, p1, b1, p2, b2));
						g_thr.push_back(t);
						g_cnt.push_back(c);
						g_pc1.push_back(p1);
						g_br1.push_back(b1);
						g_pc2.push_back(p2);
						g_br2.push_back(b2);
					end
					"cpl":
					begin
						void'($sscanf(lines[n], "%s %d %d %h", kw, t, b1, tg));
						c_idx.push_back(t);
						c_misp.push_back(b1);
						c_tgt.push_back(tg);
					end
					"wait": void'($sscanf(lines[n], "%s %d", kw, wait_n));
					"exp":
					begin
						void'($sscanf(lines[n], "%s %d %h %h", kw, t, p1, tg));
						exp_thr.push_back(t);
						exp_pc.push_back(p1);
						exp_tgt.push_back(tg);
					end
					"flush":
					begin
						void'($sscanf(lines[n], "%s %h", kw, p1));
						fl_pc.push_back(p1);
					end
					"end":
					begin
						run_test();
						clear_test();
					end
					default: ;	// comments and blank lines
				endcase
			end
			errors += dut.chk.failures;
			$display("errors: %0d", errors);
			if (errors == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dv/smt_rob_chk.sv */
/*
	Bound checker for smt_rob. Occupancy is read from the queue instances.
*/
`timescale 1ns/1ps
`default_nettype none

module smt_rob_chk #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH_DEFAULT
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic commit0_valid,
	input wire logic commit0_thread,
	input wire logic commit0_is_branch,
	input wire logic commit0_mispredict,
	input wire logic commit1_valid,
	input wire logic commit1_thread,
	input wire logic [$clog2(DEPTH):0] occ_t0,
	input wire logic [$clog2(DEPTH):0] occ_t1
);

	int failures = 0;	// assertion failures so far

	// upstream must never overrun its credits
	assert property (@(posedge clock) disable iff (reset) occ_t0 <= DEPTH && occ_t1 <= DEPTH)
		else
		begin
			$error("thread queue occupancy above DEPTH");
			failures++;
		end

	assert property (@(posedge clock) disable iff (reset) commit1_valid |-> commit0_valid)
		else
		begin
			$error("slot 1 commit without slot 0");
			failures++;
		end

	// state is only defined after the first reset edge
	assert property (@(posedge clock) $past(reset) |-> !commit0_valid && !commit1_valid)
		else
		begin
			$error("commit during reset");
			failures++;
		end

	assert property (@(posedge clock) disable iff (reset)
		commit0_valid && commit0_is_branch && commit0_mispredict && commit1_valid
		|-> commit1_thread != commit0_thread)
		else
		begin
			$error("younger entry committed behind a mispredicted branch");
			failures++;
		end

endmodule

bind smt_rob smt_rob_chk #(.DEPTH(DEPTH)) chk (
	.clock(clock),
	.reset(reset),
	.commit0_valid(commit0_valid),
	.commit0_thread(commit0_thread),
	.commit0_is_branch(commit0_is_branch),
	.commit0_mispredict(commit0_mispredict),
	.commit1_valid(commit1_valid),
	.commit1_thread(commit1_thread),
	.occ_t0(u_queue_t0.occupancy),
	.occ_t1(u_queue_t1.occupancy)
);

`default_nettype wire

/* rtl/smt_rob.sv */
/*
	Two-thread reorder buffer, DEPTH entries per thread (power of two).
	Tag is {thread, slot}. Dispatch is credit based and never back-pressured,
	so the caller must not present more entries than it holds credits for.
*/
`timescale 1ns/1ps
`default_nettype none

module smt_rob #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH_DEFAULT
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic dispatch_thread,
	input wire logic [1:0] dispatch_count,
	input wire rob_pkg::pc_t dispatch1_pc,
	input wire rob_pkg::arn_t dispatch1_arn,
	input wire rob_pkg::prn_t dispatch1_prn,
	input wire logic dispatch1_is_branch,
	input wire rob_pkg::pc_t dispatch2_pc,
	input wire rob_pkg::arn_t dispatch2_arn,
	input wire rob_pkg::prn_t dispatch2_prn,
	input wire logic dispatch2_is_branch,
	input wire logic complete1_valid,
	input wire logic [$clog2(DEPTH):0] complete1_tag,
	input wire logic complete1_mispredict,
	input wire rob_pkg::pc_t complete1_target_pc,
	input wire logic complete2_valid,
	input wire logic [$clog2(DEPTH):0] complete2_tag,
	input wire logic complete2_mispredict,
	input wire rob_pkg::pc_t complete2_target_pc,
	output logic commit0_valid,
	output logic commit0_thread,
	output rob_pkg::pc_t commit0_pc,
	output rob_pkg::pc_t commit0_target_pc,
	output rob_pkg::arn_t commit0_arn,
	output rob_pkg::prn_t commit0_prn,
	output logic commit0_is_branch,
	output logic commit0_mispredict,
	output logic commit1_valid,
	output logic commit1_thread,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::pc_t commit1_target_pc,
	output rob_pkg::arn_t commit1_arn,
	output rob_pkg::prn_t commit1_prn,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic [$clog2(DEPTH):0] dispatch_tag1,
	output logic [$clog2(DEPTH):0] dispatch_tag2,
	output logic [$clog2(DEPTH+1)-1:0] credit_t0,
	output logic [$clog2(DEPTH+1)-1:0] credit_t1
);

	localparam int SLOT_W = $clog2(DEPTH);

	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [SLOT_W:0] tag_t;

	slot_t slot_t0;
	slot_t slot_t1;
	slot_t slot_base;
	logic flush_t0;
	logic flush_t1;

	rob_commit_if t0_commit ();
	rob_commit_if t1_commit ();

	// tags come from the tail of whichever queue takes this group
	assign slot_base = dispatch_thread ? slot_t1 : slot_t0;
	assign dispatch_tag1 = (dispatch_count != 2'd0) ? tag_t'({dispatch_thread, slot_base}) : '0;
	assign dispatch_tag2 = (dispatch_count == 2'd2)
		? tag_t'({dispatch_thread, slot_t'(slot_base + 1'b1)}) : '0;

	rob_thread_queue #(
		.DEPTH(DEPTH),
		.THREAD_ID(1'b0)
	) u_queue_t0 (
		.flush(flush_t0),
		.commit(t0_commit),
		.dispatch_slot(slot_t0),
		.credit(credit_t0),
		.*
	);

	rob_thread_queue #(
		.DEPTH(DEPTH),
		.THREAD_ID(1'b1)
	) u_queue_t1 (
		.flush(flush_t1),
		.commit(t1_commit),
		.dispatch_slot(slot_t1),
		.credit(credit_t1),
		.*
	);

	rob_commit_arbiter u_arbiter (
		.t0(t0_commit),
		.t1(t1_commit),
		.*
	);

endmodule

`default_nettype wire

/* rtl/rob_commit_arbiter.sv */
/*
	Fills two commit slots from two thread heads, program order per thread.
	Consumers always accept; nothing here stalls a commit.
*/
`timescale 1ns/1ps
`default_nettype none

module rob_commit_arbiter (
	input wire logic clock,
	input wire logic reset,
	rob_commit_if.arbiter_side t0,
	rob_commit_if.arbiter_side t1,
	output logic commit0_valid,
	output logic commit0_thread,
	output rob_pkg::pc_t commit0_pc,
	output rob_pkg::pc_t commit0_target_pc,
	output rob_pkg::arn_t commit0_arn,
	output rob_pkg::prn_t commit0_prn,
	output logic commit0_is_branch,
	output logic commit0_mispredict,
	output logic commit1_valid,
	output logic commit1_thread,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::pc_t commit1_target_pc,
	output rob_pkg::arn_t commit1_arn,
	output rob_pkg::prn_t commit1_prn,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic flush_t0,
	output logic flush_t1
);
	import rob_pkg::*;

	arb_pref_t pref;
	logic head_v [2];
	logic next_v [2];
	rob_entry_t head_e [2];
	rob_entry_t next_e [2];
	logic [1:0] pop_n [2];
	logic p;
	logic s0_valid;
	logic s0_thread;
	rob_entry_t s0_e;
	logic s1_valid;
	logic s1_thread;
	rob_entry_t s1_e;

	function automatic logic is_misp(rob_entry_t e);
		return e.is_branch && e.mispredict;
	endfunction

	assign head_v[0] = t0.head_valid;
	assign head_v[1] = t1.head_valid;
	assign next_v[0] = t0.next_valid;
	assign next_v[1] = t1.next_valid;
	assign head_e[0] = t0.head_entry;
	assign head_e[1] = t1.head_entry;
	assign next_e[0] = t0.next_entry;
	assign next_e[1] = t1.next_entry;
	assign t0.pop = pop_n[0];
	assign t1.pop = pop_n[1];

	always_comb
	begin
		p = (pref == prefer_t1);
		s0_valid = 1'b0;
		s0_thread = 1'b0;
		s0_e = '0;
		s1_valid = 1'b0;
		s1_thread = 1'b0;
		s1_e = '0;
		pop_n[0] = 2'd0;
		pop_n[1] = 2'd0;
		if (head_v[p])
		begin
			s0_valid = 1'b1;
			s0_thread = p;
		end
		else if (head_v[!p])
		begin
			s0_valid = 1'b1;
			s0_thread = !p;
		end
		if (s0_valid)
		begin
			s0_e = head_e[s0_thread];
			pop_n[s0_thread] = 2'd1;
			// younger entries of a mispredicted branch must not commit
			if (next_v[s0_thread] && !is_misp(s0_e))
			begin
				s1_valid = 1'b1;
				s1_thread = s0_thread;
				s1_e = next_e[s0_thread];
				pop_n[s0_thread] = 2'd2;
			end
			else if (head_v[!s0_thread])
			begin
				s1_valid = 1'b1;
				s1_thread = !s0_thread;
				s1_e = head_e[!s0_thread];
				pop_n[!s0_thread] = 2'd1;
			end
		end
	end

	assign flush_t0 = (s0_valid && !s0_thread && is_misp(s0_e))
		|| (s1_valid && !s1_thread && is_misp(s1_e));
	assign flush_t1 = (s0_valid && s0_thread && is_misp(s0_e))
		|| (s1_valid && s1_thread && is_misp(s1_e));

	assign commit0_valid = s0_valid;
	assign commit0_thread = s0_thread;
	assign commit0_pc = s0_e.pc;
	assign commit0_target_pc = s0_e.target_pc;
	assign commit0_arn = s0_e.arn;
	assign commit0_prn = s0_e.prn;
	assign commit0_is_branch = s0_e.is_branch;
	assign commit0_mispredict = s0_e.mispredict;
	assign commit1_valid = s1_valid;
	assign commit1_thread = s1_thread;
	assign commit1_pc = s1_e.pc;
	assign commit1_target_pc = s1_e.target_pc;
	assign commit1_arn = s1_e.arn;
	assign commit1_prn = s1_e.prn;
	assign commit1_is_branch = s1_e.is_branch;
	assign commit1_mispredict = s1_e.mispredict;

	// swap preference only when both threads actually competed
	always_ff @(posedge clock)
	begin
		if (reset)
			pref <= prefer_t0;
		else if (head_v[0] && head_v[1])
			pref <= (pref == prefer_t0) ? prefer_t1 : prefer_t0;
	end

endmodule

`default_nettype wire

/* rtl/rob_thread_queue.sv */
/*
	Circular entry store for one thread. DEPTH must be a power of two.
	Overflow is not checked; the upstream stage holds one credit per entry.
	Dispatches in a flush cycle are dropped and returned as credits.
*/
`timescale 1ns/1ps
`default_nettype none

module rob_thread_queue #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
	parameter bit THREAD_ID = 1'b0
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic dispatch_thread,
	input wire logic [1:0] dispatch_count,
	input wire rob_pkg::pc_t dispatch1_pc,
	input wire rob_pkg::arn_t dispatch1_arn,
	input wire rob_pkg::prn_t dispatch1_prn,
	input wire logic dispatch1_is_branch,
	input wire rob_pkg::pc_t dispatch2_pc,
	input wire rob_pkg::arn_t dispatch2_arn,
	input wire rob_pkg::prn_t dispatch2_prn,
	input wire logic dispatch2_is_branch,
	input wire logic complete1_valid,
	input wire logic [$clog2(DEPTH):0] complete1_tag,
	input wire logic complete1_mispredict,
	input wire rob_pkg::pc_t complete1_target_pc,
	input wire logic complete2_valid,
	input wire logic [$clog2(DEPTH):0] complete2_tag,
	input wire logic complete2_mispredict,
	input wire rob_pkg::pc_t complete2_target_pc,
	input wire logic flush,
	rob_commit_if.queue_side commit,
	output logic [$clog2(DEPTH)-1:0] dispatch_slot,
	output logic [$clog2(DEPTH+1)-1:0] credit
);
	import rob_pkg::*;

	localparam int SLOT_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [SLOT_W:0] ptr_t;		// slot index plus wrap bit
	typedef logic [CNT_W-1:0] count_t;

	rob_entry_t entries [DEPTH];
	ptr_t head;
	ptr_t tail;
	ptr_t occupancy;
	ptr_t head_next;
	ptr_t tail_next;
	ptr_t disp_n;
	slot_t head_slot;
	slot_t next_slot;
	slot_t tail_slot;
	logic accept;
	logic cpl1_hit;
	logic cpl2_hit;

	// fresh entry, not yet executed
	function automatic rob_entry_t new_entry(pc_t pc, arn_t arn, prn_t prn, logic is_branch);
		rob_entry_t e;
		e = '0;
		e.pc = pc;
		e.arn = arn;
		e.prn = prn;
		e.is_branch = is_branch;
		return e;
	endfunction

	assign accept = (dispatch_thread == THREAD_ID);
	assign disp_n = accept ? ptr_t'(dispatch_count) : '0;
	assign cpl1_hit = complete1_valid && (complete1_tag[SLOT_W] == THREAD_ID);
	assign cpl2_hit = complete2_valid && (complete2_tag[SLOT_W] == THREAD_ID);

	assign occupancy = tail - head;		// wrap bit makes full distinct from empty
	assign head_slot = head[SLOT_W-1:0];
	assign next_slot = slot_t'(head_slot + 1'b1);
	assign tail_slot = tail[SLOT_W-1:0];
	assign dispatch_slot = tail_slot;

	assign commit.head_valid = (occupancy != '0) && entries[head_slot].done;
	assign commit.head_entry = entries[head_slot];
	assign commit.next_valid = (occupancy > ptr_t'(1)) && entries[next_slot].done;
	assign commit.next_entry = entries[next_slot];

	assign head_next = head + ptr_t'(commit.pop);
	// a flush drops everything behind the new head, same-cycle dispatches included
	assign tail_next = flush ? head_next : tail + disp_n;

	// flush frees the whole queue, committed entries included
	assign credit = flush ? count_t'(occupancy + disp_n) : count_t'(commit.pop);

	always_ff @(posedge clock)
	begin
		if (accept && dispatch_count != 2'd0)
			entries[tail_slot] <= new_entry(dispatch1_pc, dispatch1_arn,
				dispatch1_prn, dispatch1_is_branch);
		if (accept && dispatch_count == 2'd2)
			entries[slot_t'(tail_slot + 1'b1)] <= new_entry(dispatch2_pc, dispatch2_arn,
				dispatch2_prn, dispatch2_is_branch);
		if (cpl1_hit)
		begin
			entries[complete1_tag[SLOT_W-1:0]].done <= 1'b1;
			entries[complete1_tag[SLOT_W-1:0]].mispredict <= complete1_mispredict;
			entries[complete1_tag[SLOT_W-1:0]].target_pc <= complete1_target_pc;
		end
		if (cpl2_hit)
		begin
			entries[complete2_tag[SLOT_W-1:0]].done <= 1'b1;
			entries[complete2_tag[SLOT_W-1:0]].mispredict <= complete2_mispredict;
			entries[complete2_tag[SLOT_W-1:0]].target_pc <= complete2_target_pc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			head <= head_next;
			tail <= tail_next;
		end
	end

endmodule

`default_nettype wire

/* rtl/rob_commit_if.sv */
/*
	Head view of one thread queue as seen by the commit arbiter.
	pop is only legal up to the number of valid heads offered.
*/
`timescale 1ns/1ps
`default_nettype none

interface rob_commit_if;
	import rob_pkg::*;

	logic head_valid;		// oldest entry present and done
	rob_entry_t head_entry;
	logic next_valid;		// second oldest present and done
	rob_entry_t next_entry;
	logic [1:0] pop;		// entries taken this cycle, 0 to 2

	modport queue_side (
		output head_valid, head_entry, next_valid, next_entry,
		input pop
	);

	modport arbiter_side (
		input head_valid, head_entry, next_valid, next_entry,
		output pop
	);

endinterface

`default_nettype wire

/* rtl/rob_pkg.sv */
/*
	Shared widths and types for the two-thread reorder buffer.
	PRF_SIZE is assumed to be a power of two so prn_t covers it exactly.
*/
`default_nettype none

package rob_pkg;

	localparam int ROB_DEPTH_DEFAULT = 16;	// entries per thread
	localparam int PRF_SIZE = 64;

	typedef logic [63:0] pc_t;
	typedef logic [4:0] arn_t;
	typedef logic [$clog2(PRF_SIZE)-1:0] prn_t;

	// one buffer slot as stored in a thread queue
	typedef struct packed {
		pc_t pc;
		pc_t target_pc;		// written by completion
		arn_t arn;
		prn_t prn;
		logic is_branch;
		logic done;
		logic mispredict;
	} rob_entry_t;

	// which thread gets slot 0 when both heads are ready
	typedef enum logic {
		prefer_t0,
		prefer_t1
	} arb_pref_t;

endpackage

`default_nettype wire
